// ==== Bender.yml ====
package:
  name: audio_controller

sources:
  - files:
      - rtl/audio_pkg.sv
      - rtl/audio_regs.sv
      - rtl/audio_channel.sv
      - rtl/dma_scheduler.sv
      - rtl/audio_mixer.sv
      - rtl/audio_controller.sv
  - target: test
    files:
      - verification/audio_controller_checker.sv
      - verification/audio_controller_tb.sv

// ==== compile.f ====
rtl/audio_pkg.sv
rtl/audio_regs.sv
rtl/audio_channel.sv
rtl/dma_scheduler.sv
rtl/audio_mixer.sv
rtl/audio_controller.sv
verification/audio_controller_checker.sv
verification/audio_controller_tb.sv

// ==== rtl/audio_channel.sv ====
// Playback channel with address and word counters, one-word sample buffer and DMA request
module audio_channel (
	input logic i_clock,
	input logic i_rst,

	input audio_pkg::ch_setup_t i_setup,

	output audio_pkg::ch_dma_req_t o_dma,
	input logic i_dma_ready,
	input logic [audio_pkg::WORD_W-1:0] i_dma_rdata,

	input logic i_sample_tick,
	output logic o_busy,
	output audio_pkg::stereo_t o_sample
);

	import audio_pkg::*;

	logic [WORD_W-1:0] address_q;
	logic [WORD_W-1:0] count_q;
	logic full_q;
	stereo_t buffer_q;

	// Words left to fetch
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			count_q <= '0;
		end else if (i_setup.start) begin
			count_q <= i_setup.count;
		end else if (i_dma_ready) begin
			count_q <= count_q - 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_setup.start) begin
			address_q <= i_setup.address;
		end else if (i_dma_ready) begin
			address_q <= address_q + WORD_BYTES;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_dma_ready) begin
			buffer_q <= i_dma_rdata;
		end
	end

	// Ready only arrives while the buffer is empty
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			full_q <= 1'b0;
			o_sample <= '0;
		end else begin
			if (i_sample_tick) begin
				o_sample <= full_q ? buffer_q : '0;
				full_q <= 1'b0;
			end
			if (i_dma_ready) begin
				full_q <= 1'b1;
			end
		end
	end

	always_comb begin
		o_dma.request = (count_q != '0) && !full_q;
		o_dma.address = address_q;
	end

	assign o_busy = (count_q != '0) || full_q;

endmodule

// ==== rtl/audio_controller.sv ====
// Audio DMA controller top with sample clock edge detector, registers, channels, scheduler and mixer
module audio_controller (
	input logic i_clock,
	input logic i_rst,

	input logic i_request,
	input logic i_rw,
	input logic [audio_pkg::REG_ADDR_W-1:0] i_address,
	input logic [audio_pkg::WORD_W-1:0] i_wdata,
	output logic [audio_pkg::WORD_W-1:0] o_rdata,
	output logic o_ready,

	output logic o_dma_request,
	output logic [audio_pkg::WORD_W-1:0] o_dma_address,
	input logic i_dma_ready,
	input logic [audio_pkg::WORD_W-1:0] i_dma_rdata,

	input logic i_output_sample_clock,
	output logic [audio_pkg::WORD_W-1:0] o_output_sample_rate,
	output logic [audio_pkg::SAMPLE_W-1:0] o_output_sample_left,
	output logic [audio_pkg::SAMPLE_W-1:0] o_output_sample_right
);

	import audio_pkg::*;

	logic sample_clock_q;
	logic sample_clock_prev_q;
	logic sample_tick;

	ch_setup_t setup [NUM_CHANNELS];
	ch_dma_req_t dma_req [NUM_CHANNELS];
	logic [NUM_CHANNELS-1:0] ch_ready;
	logic [NUM_CHANNELS-1:0] busy;
	stereo_t samples [NUM_CHANNELS];
	stereo_t mix;

	// External sample clock is registered before edge detection
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			sample_clock_q <= 1'b0;
			sample_clock_prev_q <= 1'b0;
		end else begin
			sample_clock_q <= i_output_sample_clock;
			sample_clock_prev_q <= sample_clock_q;
		end
	end

	assign sample_tick = sample_clock_q & ~sample_clock_prev_q;

	audio_regs u_regs (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.i_busy(busy),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_sample_rate(o_output_sample_rate),
		.o_setup(setup)
	);

	for (genvar n = 0; n < NUM_CHANNELS; n++) begin : g_channel
		audio_channel u_channel (
			.i_clock(i_clock),
			.i_rst(i_rst),
			.i_setup(setup[n]),
			.o_dma(dma_req[n]),
			.i_dma_ready(ch_ready[n]),
			.i_dma_rdata(i_dma_rdata),
			.i_sample_tick(sample_tick),
			.o_busy(busy[n]),
			.o_sample(samples[n])
		);
	end

	dma_scheduler u_scheduler (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_req(dma_req),
		.o_ch_ready(ch_ready),
		.o_dma_request(o_dma_request),
		.o_dma_address(o_dma_address),
		.i_dma_ready(i_dma_ready)
	);

	audio_mixer u_mixer (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_samples(samples),
		.o_mix(mix)
	);

	assign o_output_sample_left = mix.left;
	assign o_output_sample_right = mix.right;

endmodule

// ==== rtl/audio_mixer.sv ====
// Registered stereo mixer with wrapping 16-bit sums
module audio_mixer (
	input logic i_clock,
	input logic i_rst,

	input audio_pkg::stereo_t i_samples [audio_pkg::NUM_CHANNELS],
	output audio_pkg::stereo_t o_mix
);

	import audio_pkg::*;

	stereo_t mix_d;

	// Overflow simply wraps
	always_comb begin
		mix_d = '0;
		for (int n = 0; n < NUM_CHANNELS; n++) begin
			mix_d.left = mix_d.left + i_samples[n].left;
			mix_d.right = mix_d.right + i_samples[n].right;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_mix <= '0;
		end else begin
			o_mix <= mix_d;
		end
	end

endmodule

// ==== rtl/audio_pkg.sv ====
// Constants, register map and shared structs of the audio DMA controller
package audio_pkg;

	localparam int NUM_CHANNELS = 4;
	localparam int CH_IDX_W = 2;
	localparam int WORD_W = 32;
	localparam int SAMPLE_W = 16;
	localparam int REG_ADDR_W = 4;

	// System clock / (256 * 22050)
	localparam logic [WORD_W-1:0] DEFAULT_SAMPLE_RATE = 32'd17;

	// Address step per fetched word
	localparam logic [WORD_W-1:0] WORD_BYTES = 32'd4;

	// CPU register map
	localparam logic [REG_ADDR_W-1:0] REG_SAMPLE_RATE = 4'd0;
	localparam logic [REG_ADDR_W-1:0] REG_BUSY = 4'd1;
	// Channel n address at base + 2n, count at base + 2n + 1
	localparam logic [REG_ADDR_W-1:0] REG_CH_BASE = 4'd1;

	// Left sample sits in the upper half of a DMA word
	typedef struct packed {
		logic signed [SAMPLE_W-1:0] left;
		logic signed [SAMPLE_W-1:0] right;
	} stereo_t;

	typedef struct packed {
		logic start;
		logic [WORD_W-1:0] address;
		logic [WORD_W-1:0] count;
	} ch_setup_t;

	typedef struct packed {
		logic request;
		logic [WORD_W-1:0] address;
	} ch_dma_req_t;

endpackage

// ==== rtl/audio_regs.sv ====
// CPU register block with sample rate, busy readback and channel setup strobes
module audio_regs (
	input logic i_clock,
	input logic i_rst,

	input logic i_request,
	input logic i_rw,
	input logic [audio_pkg::REG_ADDR_W-1:0] i_address,
	input logic [audio_pkg::WORD_W-1:0] i_wdata,
	input logic [audio_pkg::NUM_CHANNELS-1:0] i_busy,
	output logic [audio_pkg::WORD_W-1:0] o_rdata,
	output logic o_ready,

	output logic [audio_pkg::WORD_W-1:0] o_sample_rate,
	output audio_pkg::ch_setup_t o_setup [audio_pkg::NUM_CHANNELS]
);

	import audio_pkg::*;

	logic access;
	logic write;
	logic [WORD_W-1:0] busy_word;
	logic [NUM_CHANNELS-1:0] addr_hit;
	logic [NUM_CHANNELS-1:0] count_hit;
	logic [NUM_CHANNELS-1:0] setup_start;
	logic [WORD_W-1:0] setup_address [NUM_CHANNELS];
	logic [WORD_W-1:0] setup_count [NUM_CHANNELS];

	// One access per request, taken while ready is still low
	assign access = i_request & ~o_ready;
	assign write = access & i_rw;
	assign busy_word = WORD_W'(i_busy);

	always_comb begin
		for (int n = 0; n < NUM_CHANNELS; n++) begin
			addr_hit[n] = i_address == REG_ADDR_W'(REG_CH_BASE + 2 * n);
			count_hit[n] = i_address == REG_ADDR_W'(REG_CH_BASE + 2 * n + 1);
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_ready <= 1'b0;
			o_sample_rate <= DEFAULT_SAMPLE_RATE;
			setup_start <= '0;
		end else begin
			setup_start <= write ? count_hit : '0;
			if (write && i_address == REG_SAMPLE_RATE) begin
				o_sample_rate <= i_wdata;
			end
			if (access) begin
				o_ready <= 1'b1;
			end else if (!i_request) begin
				o_ready <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (access && !i_rw) begin
			if (i_address == REG_SAMPLE_RATE) begin
				o_rdata <= o_sample_rate;
			end else if (i_address == REG_BUSY) begin
				o_rdata <= busy_word;
			end
		end
		for (int n = 0; n < NUM_CHANNELS; n++) begin
			if (write && addr_hit[n]) begin
				setup_address[n] <= i_wdata;
			end
			if (write && count_hit[n]) begin
				setup_count[n] <= i_wdata;
			end
		end
	end

	always_comb begin
		for (int n = 0; n < NUM_CHANNELS; n++) begin
			o_setup[n].start = setup_start[n];
			o_setup[n].address = setup_address[n];
			o_setup[n].count = setup_count[n];
		end
	end

endmodule

// ==== rtl/dma_scheduler.sv ====
// Round-robin arbiter for the shared DMA bus master
module dma_scheduler (
	input logic i_clock,
	input logic i_rst,

	input audio_pkg::ch_dma_req_t i_req [audio_pkg::NUM_CHANNELS],
	output logic [audio_pkg::NUM_CHANNELS-1:0] o_ch_ready,

	output logic o_dma_request,
	output logic [audio_pkg::WORD_W-1:0] o_dma_address,
	input logic i_dma_ready
);

	import audio_pkg::*;

	logic [CH_IDX_W-1:0] ptr_q;

	// Pointer stays on the granted channel until its word arrives
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			ptr_q <= '0;
			o_dma_request <= 1'b0;
		end else if (o_dma_request) begin
			if (i_dma_ready) begin
				o_dma_request <= 1'b0;
				ptr_q <= ptr_q + 1'b1;
			end
		end else if (i_req[ptr_q].request) begin
			o_dma_request <= 1'b1;
		end else begin
			ptr_q <= ptr_q + 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (!o_dma_request && i_req[ptr_q].request) begin
			o_dma_address <= i_req[ptr_q].address;
		end
	end

	always_comb begin
		o_ch_ready = '0;
		o_ch_ready[ptr_q] = o_dma_request & i_dma_ready;
	end

endmodule

// ==== verification/audio_controller_checker.sv ====
// Concurrent assertions on the CPU and DMA handshakes of the audio DMA controller
module audio_controller_checker (
	input logic i_clock,
	input logic i_rst,
	input logic i_request,
	input logic o_ready,
	input logic o_dma_request,
	input logic [audio_pkg::WORD_W-1:0] o_dma_address,
	input logic i_dma_ready
);

	// Request and address hold until memory answers
	dma_request_held: assert property (
		@(posedge i_clock) disable iff (i_rst)
		o_dma_request && !i_dma_ready |=> o_dma_request && $stable(o_dma_address)
	) else $error("o_dma_request or o_dma_address changed before i_dma_ready");

	ready_held: assert property (
		@(posedge i_clock) disable iff (i_rst)
		o_ready && i_request |=> o_ready
	) else $error("o_ready fell while i_request was high");

	// Ready rises one cycle after the access
	ready_needs_request: assert property (
		@(posedge i_clock) disable iff (i_rst)
		$rose(o_ready) |-> $past(i_request)
	) else $error("o_ready rose without i_request");

endmodule

bind audio_controller audio_controller_checker u_checker (.*);

// ==== verification/audio_controller_tb.sv ====
// Testbench for the audio DMA controller with memory model, stimulus table, reference model and watchdog
module audio_controller_tb;

	import audio_pkg::*;

	localparam int CLOCK_PERIOD = 100;
	localparam int RESET_CYCLES = 8;
	localparam int SEED = 1400;
	localparam int NUM_ROWS = 3;
	localparam int MAX_WORDS = 4;
	localparam int TICK_CYCLES = 60;
	localparam int READY_TIMEOUT = 20;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * MAX_WORDS * 80 + 2000;
	localparam logic [WORD_W-1:0] RESET_RATE = 32'd17;
	localparam logic [WORD_W-1:0] NEW_RATE = 32'd48;

	// Start address and word count per row and channel
	localparam logic [WORD_W-1:0] ROW_ADDRESS [NUM_ROWS][NUM_CHANNELS] = '{
		'{32'h0010_0020, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000},
		'{32'h7ff0_4000, 32'h6000_7000, 32'h0100_f000, 32'ha000_0010},
		'{32'h0000_0000, 32'h1234_5678, 32'h0000_0000, 32'hffff_fff0}
	};
	localparam int ROW_COUNT [NUM_ROWS][NUM_CHANNELS] = '{
		'{3, 0, 0, 0},
		'{2, 3, 1, 4},
		'{0, 2, 0, 3}
	};

	logic i_clock;
	logic i_rst;
	logic i_request;
	logic i_rw;
	logic [REG_ADDR_W-1:0] i_address;
	logic [WORD_W-1:0] i_wdata;
	logic [WORD_W-1:0] o_rdata;
	logic o_ready;
	logic o_dma_request;
	logic [WORD_W-1:0] o_dma_address;
	logic i_dma_ready;
	logic [WORD_W-1:0] i_dma_rdata;
	logic i_output_sample_clock;
	logic [WORD_W-1:0] o_output_sample_rate;
	logic [SAMPLE_W-1:0] o_output_sample_left;
	logic [SAMPLE_W-1:0] o_output_sample_right;

	int errors;
	int last_grant;
	// Reference model of the channels
	logic [WORD_W-1:0] next_address [NUM_CHANNELS];
	int remaining [NUM_CHANNELS];
	logic buffered [NUM_CHANNELS];
	logic [WORD_W-1:0] buffer_word [NUM_CHANNELS];
	logic [WORD_W-1:0] played_word [NUM_CHANNELS];

	audio_controller DUT (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_dma_request(o_dma_request),
		.o_dma_address(o_dma_address),
		.i_dma_ready(i_dma_ready),
		.i_dma_rdata(i_dma_rdata),
		.i_output_sample_clock(i_output_sample_clock),
		.o_output_sample_rate(o_output_sample_rate),
		.o_output_sample_left(o_output_sample_left),
		.o_output_sample_right(o_output_sample_right)
	);

	initial begin
		i_clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) i_clock = ~i_clock;
	end

	task automatic report_mismatch(input string name, input logic [WORD_W-1:0] got,
			input logic [WORD_W-1:0] expected);
		$display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, expected);
		errors++;
	endtask

	// One CPU access with the request/ready level protocol
	task automatic cpu_access(input logic rw, input logic [REG_ADDR_W-1:0] address,
			input logic [WORD_W-1:0] wdata, output logic [WORD_W-1:0] rdata);
		int waited;
		@(negedge i_clock);
		i_request = 1'b1;
		i_rw = rw;
		i_address = address;
		i_wdata = wdata;
		waited = 0;
		do begin
			@(negedge i_clock);
			waited++;
		end while (!o_ready && waited < READY_TIMEOUT);
		if (!o_ready) begin
			$display("Error at %0t: o_ready never rose for address %0d", $time, address);
			errors++;
		end
		rdata = o_rdata;
		// Request stays up one more cycle, ready must hold
		@(negedge i_clock);
		if (!o_ready) begin
			$display("Error at %0t: o_ready fell while i_request was still high", $time);
			errors++;
		end
		i_request = 1'b0;
		@(negedge i_clock);
		if (o_ready) begin
			$display("Error at %0t: o_ready stayed high after i_request fell", $time);
			errors++;
		end
	endtask

	function automatic logic [WORD_W-1:0] expected_busy();
		logic [WORD_W-1:0] mask;
		mask = '0;
		for (int n = 0; n < NUM_CHANNELS; n++) begin
			mask[n] = remaining[n] > 0 || buffered[n];
		end
		return mask;
	endfunction

	// Left in the upper half, right in the lower, each summed mod 2^16
	function automatic logic [WORD_W-1:0] expected_mix();
		logic [SAMPLE_W-1:0] left;
		logic [SAMPLE_W-1:0] right;
		left = '0;
		right = '0;
		for (int n = 0; n < NUM_CHANNELS; n++) begin
			left = left + played_word[n][31:16];
			right = right + played_word[n][15:0];
		end
		return {left, right};
	endfunction

	task automatic sample_tick();
		logic [WORD_W-1:0] mix;
		logic [WORD_W-1:0] busy;
		@(negedge i_clock);
		for (int n = 0; n < NUM_CHANNELS; n++) begin
			played_word[n] = buffered[n] ? buffer_word[n] : '0;
			buffered[n] = 1'b0;
		end
		last_grant = -1;
		i_output_sample_clock = 1'b1;
		repeat (5) @(negedge i_clock);
		mix = expected_mix();
		if (o_output_sample_left !== mix[31:16]) begin
			report_mismatch("o_output_sample_left", o_output_sample_left, mix[31:16]);
		end
		if (o_output_sample_right !== mix[15:0]) begin
			report_mismatch("o_output_sample_right", o_output_sample_right, mix[15:0]);
		end
		cpu_access(1'b0, REG_BUSY, '0, busy);
		if (busy !== expected_busy()) begin
			report_mismatch("busy mask", busy, expected_busy());
		end
		repeat (TICK_CYCLES / 2 - 9) @(negedge i_clock);
		i_output_sample_clock = 1'b0;
		repeat (TICK_CYCLES / 2) @(negedge i_clock);
	endtask

	// Memory answers with the address itself after a random delay
	initial begin
		int delay;
		int grant;
		delay = $urandom(SEED);
		forever begin
			@(negedge i_clock);
			if (o_dma_request && !i_dma_ready) begin
				grant = -1;
				for (int n = 0; n < NUM_CHANNELS; n++) begin
					if (remaining[n] > 0 && !buffered[n] && next_address[n] == o_dma_address) begin
						grant = n;
					end
				end
				if (grant < 0) begin
					$display("Error at %0t: DMA address %h fits no requesting channel",
						$time, o_dma_address);
					errors++;
				end else begin
					// Requesters between the previous grant and this one were skipped
					if (last_grant >= 0) begin
						for (int c = (last_grant + 1) % NUM_CHANNELS; c != grant;
								c = (c + 1) % NUM_CHANNELS) begin
							if (remaining[c] > 0 && !buffered[c]) begin
								$display("Error at %0t: channel %0d granted while channel %0d waits",
									$time, grant, c);
								errors++;
							end
						end
					end
					buffer_word[grant] = next_address[grant];
					buffered[grant] = 1'b1;
					next_address[grant] = next_address[grant] + WORD_BYTES;
					remaining[grant]--;
					last_grant = grant;
				end
				delay = $urandom % 4;
				repeat (delay) @(negedge i_clock);
				i_dma_ready = 1'b1;
				i_dma_rdata = o_dma_address;
				@(negedge i_clock);
				i_dma_ready = 1'b0;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge i_clock);
		$display("Error: run timed out after %0d cycles with %0d errors", WATCHDOG_CYCLES, errors);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		logic [WORD_W-1:0] rdata;
		int ticks;
		errors = 0;
		last_grant = -1;
		i_rst = 1'b1;
		i_request = 1'b0;
		i_rw = 1'b0;
		i_address = '0;
		i_wdata = '0;
		i_dma_ready = 1'b0;
		i_dma_rdata = '0;
		i_output_sample_clock = 1'b0;
		for (int n = 0; n < NUM_CHANNELS; n++) begin
			next_address[n] = '0;
			remaining[n] = 0;
			buffered[n] = 1'b0;
			buffer_word[n] = '0;
			played_word[n] = '0;
		end
		repeat (RESET_CYCLES) @(negedge i_clock);
		i_rst = 1'b0;
		@(negedge i_clock);

		if (o_ready !== 1'b0) report_mismatch("o_ready", o_ready, 0);
		if (o_dma_request !== 1'b0) report_mismatch("o_dma_request", o_dma_request, 0);
		if (o_output_sample_left !== '0) begin
			report_mismatch("o_output_sample_left", o_output_sample_left, 0);
		end
		if (o_output_sample_right !== '0) begin
			report_mismatch("o_output_sample_right", o_output_sample_right, 0);
		end
		cpu_access(1'b0, REG_SAMPLE_RATE, '0, rdata);
		if (rdata !== RESET_RATE) report_mismatch("sample rate read", rdata, RESET_RATE);

		cpu_access(1'b1, REG_SAMPLE_RATE, NEW_RATE, rdata);
		if (o_output_sample_rate !== NEW_RATE) begin
			report_mismatch("o_output_sample_rate", o_output_sample_rate, NEW_RATE);
		end
		cpu_access(1'b0, REG_SAMPLE_RATE, '0, rdata);
		if (rdata !== NEW_RATE) report_mismatch("sample rate read", rdata, NEW_RATE);

		for (int row = 0; row < NUM_ROWS; row++) begin
			ticks = 0;
			for (int n = 0; n < NUM_CHANNELS; n++) begin
				cpu_access(1'b1, REG_ADDR_W'(REG_CH_BASE + 2 * n), ROW_ADDRESS[row][n], rdata);
				remaining[n] = ROW_COUNT[row][n];
				next_address[n] = ROW_ADDRESS[row][n];
				last_grant = -1;
				cpu_access(1'b1, REG_ADDR_W'(REG_CH_BASE + 2 * n + 1), ROW_COUNT[row][n], rdata);
				if (ROW_COUNT[row][n] > ticks) ticks = ROW_COUNT[row][n];
			end
			// First words are fetched before the first tick
			repeat (20) @(negedge i_clock);
			cpu_access(1'b0, REG_BUSY, '0, rdata);
			if (rdata !== expected_busy()) report_mismatch("busy mask", rdata, expected_busy());
			repeat (ticks + 1) sample_tick();
		end

		$display("Run complete with %0d errors", errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule
